// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = ebusTb
FILELIST = sim.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

// ==== sim.f ====
src/ebusPkg.sv
src/ebusIf.sv
src/ebusFifo.sv
src/ebusCtl.sv
src/ebusDev.sv
src/ebusMux.sv
src/ebusTop.sv
verification/ebusCtl_assert.sv
verification/ebusTb.sv

// ==== src/ebusCtl.sv ====
`timescale 1ns/1ps

module ebusCtl #(
  parameter int NumDev = 4
) (
  input  logic               clk60,
  input  logic               rstN,
  ebusIf.ctl                 bus,
  // Command FIFO
  input  logic               cmdEmpty,
  input  ebusPkg::tEbusCmd   cmdHead,
  output logic               cmdPop,
  // Response FIFO
  input  int unsigned        respFree,
  output logic               respPush,
  output ebusPkg::tEbusResp  respPushData,
  input  logic               respEmpty,
  output logic               respPop,
  // Host side
  output logic               cmdCredit,
  input  logic               respCredit,
  output logic               respValid
);

  logic              issueBusy;    // Issue stage holds a bus cycle
  logic              headRead;
  logic              headPresent;  // Head addresses an existing device
  logic              roomOk;
  logic              capRead;      // Capture stage has a read to push
  ebusPkg::tDevId    capDev;
  logic [7:0]        creditCnt;    // Host response credits
  logic              respGo;

  // Issue decision for the command at the head
  assign headRead    = ebusPkg::isRead(cmdHead.func);
  assign headPresent = int'(cmdHead.dev) < NumDev;

  // A read needs two free slots, one may already be owed to the capture stage
  assign roomOk = !headRead || (respFree >= 2);

  assign cmdPop    = !cmdEmpty && !issueBusy && roomOk;  // At most every other cycle
  assign cmdCredit = cmdPop;                             // Each pop frees a host credit

  // Issue stage, bus cycle in T+1
  always_ff @(posedge clk60) begin
    if (!rstN) begin
      issueBusy  <= 1'b0;
      bus.demand <= 1'b0;
    end else begin
      issueBusy  <= cmdPop;
      // Writes to absent ids need no bus cycle, reads still run and return zero
      bus.demand <= cmdPop && (headRead || headPresent);
    end
  end

  always_ff @(posedge clk60) begin
    if (cmdPop) begin
      bus.cs     <= cmdHead.dev;
      bus.func   <= cmdHead.func;
      bus.dataWr <= cmdHead.data;
    end
  end

  // Capture stage, mux data is valid in T+2
  always_ff @(posedge clk60) begin
    if (!rstN) begin
      capRead <= 1'b0;
    end else begin
      capRead <= bus.demand && ebusPkg::isRead(bus.func);
    end
  end

  always_ff @(posedge clk60) begin
    capDev <= bus.cs;  // Id follows the read into the response
  end

  assign respPush          = capRead;
  assign respPushData.dev  = capDev;
  assign respPushData.data = bus.data;

  // Response release, head stays put during the respValid cycle
  assign respGo  = !respEmpty && (creditCnt != '0) && !respValid;
  assign respPop = respValid;  // Head leaves as the host sees it

  always_ff @(posedge clk60) begin
    if (!rstN) begin
      respValid <= 1'b0;
      creditCnt <= '0;
    end else begin
      respValid <= respGo;
      // Credit spent when the response leaves
      creditCnt <= creditCnt + 8'(respCredit) - 8'(respPop);
    end
  end

endmodule

// ==== src/ebusDev.sv ====
`timescale 1ns/1ps

module ebusDev #(
  parameter int DevId = 0
) (
  input  logic clk60,
  input  logic rstN,
  ebusIf.dev   bus
);

  ebusPkg::tEbusWord dataReg;   // DATAO/DATAI register
  logic [18:35]      condReg;   // Conditions, right half only
  logic              sel;       // Addressed in this bus cycle
  logic              rdSel;     // Addressed read
  ebusPkg::tEbusWord rdWord;

  // Select decode on cs
  assign sel   = bus.demand && (bus.cs == ebusPkg::tDevId'(DevId));
  assign rdSel = sel && ebusPkg::isRead(bus.func);

  // CONI returns the conditions in the right half, left half zero
  always_comb begin
    if (bus.func == ebusPkg::fDatai) begin
      rdWord = dataReg;
    end else begin
      rdWord = {18'b0, condReg};
    end
  end

  // Drive only while addressed for a read
  assign bus.driving[DevId] = rdSel;
  assign bus.drvData[DevId] = rdSel ? rdWord : '0;

  // Register writes land at the end of the demand cycle
  always_ff @(posedge clk60) begin
    if (!rstN) begin
      dataReg <= '0;
      condReg <= '0;
    end else if (sel) begin
      case (bus.func)
        ebusPkg::fDatao: dataReg <= bus.dataWr;         // Full word
        ebusPkg::fCono:  condReg <= bus.dataWr[18:35];  // Right half
        default: ;                                      // Reads change nothing
      endcase
    end
  end

endmodule

// ==== src/ebusFifo.sv ====
`timescale 1ns/1ps

module ebusFifo #(
  parameter type tItem = logic [7:0],
  parameter int  Depth = 4
) (
  input  logic        clk60,
  input  logic        rstN,
  input  logic        push,
  input  tItem        pushData,
  input  logic        pop,
  output tItem        popData,
  output logic        empty,
  output logic        full,
  output int unsigned freeCount
);

  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW = $clog2(Depth + 1);

  tItem            mem [Depth];  // Storage, no reset
  logic [PtrW-1:0] rdPtr;
  logic [PtrW-1:0] wrPtr;
  logic [CntW-1:0] count;        // Occupancy
  logic            doPush;
  logic            doPop;

  // Wrap at Depth so any depth works, not only powers of two
  function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] p);
    return (p == PtrW'(Depth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign doPush    = push && !full;   // Overflow push is dropped
  assign doPop     = pop && !empty;   // Underflow pop is ignored
  assign empty     = (count == '0);
  assign full      = (count == CntW'(Depth));
  assign freeCount = Depth - int'(count);
  assign popData   = mem[rdPtr];      // Head is visible without a pop

  always_ff @(posedge clk60) begin
    if (!rstN) begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) wrPtr <= nextPtr(wrPtr);
      if (doPop)  rdPtr <= nextPtr(rdPtr);
      count <= count + CntW'(doPush) - CntW'(doPop);  // Both at once keeps count
    end
  end

  always_ff @(posedge clk60) begin
    if (doPush) mem[wrPtr] <= pushData;
  end

endmodule

// ==== src/ebusIf.sv ====
`timescale 1ns/1ps

interface ebusIf #(
  parameter int NumDev = 4
);

  // Controller side of the bus cycle
  ebusPkg::tDevId    cs;      // Selected device
  ebusPkg::tEbusFunc func;    // DATAO/DATAI/CONO/CONI
  logic              demand;  // One-cycle bus strobe
  ebusPkg::tEbusWord dataWr;  // Write data to devices

  // Per-device drivers, each device owns one index
  logic [0:NumDev-1] driving;
  ebusPkg::tEbusWord drvData [NumDev];

  // Muxed and registered bus data
  ebusPkg::tEbusWord data;

  modport ctl (output cs, func, demand, dataWr, input data);
  modport dev (input cs, func, demand, dataWr, output driving, drvData);
  modport mux (input driving, drvData, output data);

endinterface

// ==== src/ebusMux.sv ====
`timescale 1ns/1ps

module ebusMux #(
  parameter int NumDev = 4
) (
  input  logic clk60,
  input  logic rstN,
  ebusIf.mux   bus
);

  ebusPkg::tEbusWord sel;  // Selected driver word

  // AND-OR select, decode keeps driving one-hot
  // Nothing driving gives zero, so absent ids read as zero
  always_comb begin
    sel = '0;
    for (int i = 0; i < NumDev; i++) begin
      sel = sel | (bus.drvData[i] & {$bits(ebusPkg::tEbusWord){bus.driving[i]}});
    end
  end

  // One cycle capture onto the bus data
  always_ff @(posedge clk60) begin
    if (!rstN) begin
      bus.data <= '0;
    end else begin
      bus.data <= sel;
    end
  end

endmodule

// ==== src/ebusPkg.sv ====
package ebusPkg;

  // EBUS word, bit 0 is the MSB as on the real machine
  typedef logic [0:35] tEbusWord;

  // Device select code on the cs lines
  typedef logic [0:2] tDevId;

  // Function codes carried on the func lines
  typedef enum logic [1:0] {
    fDatao = 2'd0,  // Write data register
    fDatai = 2'd1,  // Read data register
    fCono  = 2'd2,  // Write conditions, bits 18..35
    fConi  = 2'd3   // Read conditions, zero-extended
  } tEbusFunc;

  // Command queue item, 41 bits
  typedef struct packed {
    tDevId    dev;
    tEbusFunc func;
    tEbusWord data;
  } tEbusCmd;

  // Response queue item, 39 bits
  typedef struct packed {
    tDevId    dev;
    tEbusWord data;
  } tEbusResp;

  // True for the functions that return a word to the host
  function automatic logic isRead(input tEbusFunc f);
    return (f == fDatai) || (f == fConi);
  endfunction

endpackage

// ==== src/ebusTop.sv ====
`timescale 1ns/1ps

module ebusTop #(
  parameter int NumDev    = 4,
  parameter int CmdDepth  = 4,
  parameter int RespDepth = 4
) (
  input  logic               clk60,
  input  logic               rstN,
  // Command side
  input  logic               cmdValid,
  input  ebusPkg::tDevId     cmdDev,
  input  ebusPkg::tEbusFunc  cmdFunc,
  input  ebusPkg::tEbusWord  cmdData,
  output logic               cmdCredit,
  // Response side
  input  logic               respCredit,
  output logic               respValid,
  output ebusPkg::tDevId     respDev,
  output ebusPkg::tEbusWord  respData
);

  ebusIf #(.NumDev(NumDev)) bus();

  ebusPkg::tEbusCmd  cmdItem;     // Packed host command
  ebusPkg::tEbusCmd  cmdHead;
  logic              cmdEmpty;
  logic              cmdPop;
  ebusPkg::tEbusResp respItem;
  ebusPkg::tEbusResp respHead;
  logic              respPush;
  logic              respPop;
  logic              respEmpty;
  int unsigned       respFree;

  assign cmdItem.dev  = cmdDev;
  assign cmdItem.func = cmdFunc;
  assign cmdItem.data = cmdData;

  // Host sees the head during respValid
  assign respDev  = respHead.dev;
  assign respData = respHead.data;

  // Host credits keep cmdValid from overflowing this queue
  ebusFifo #(.tItem(ebusPkg::tEbusCmd), .Depth(CmdDepth)) cmdQ (
    .clk60, .rstN,
    .push(cmdValid), .pushData(cmdItem),
    .pop(cmdPop), .popData(cmdHead),
    .empty(cmdEmpty), .full(), .freeCount()
  );

  ebusFifo #(.tItem(ebusPkg::tEbusResp), .Depth(RespDepth)) respQ (
    .clk60, .rstN,
    .push(respPush), .pushData(respItem),
    .pop(respPop), .popData(respHead),
    .empty(respEmpty), .full(), .freeCount(respFree)
  );

  ebusCtl #(.NumDev(NumDev)) ctl0 (
    .clk60, .rstN, .bus(bus.ctl),
    .cmdEmpty, .cmdHead, .cmdPop,
    .respFree, .respPush, .respPushData(respItem), .respEmpty, .respPop,
    .cmdCredit, .respCredit, .respValid
  );

  ebusMux #(.NumDev(NumDev)) mux0 (.clk60, .rstN, .bus(bus.mux));

  // One register block per device id
  for (genvar i = 0; i < NumDev; i++) begin : dev
    ebusDev #(.DevId(i)) regs (.clk60, .rstN, .bus(bus.dev));
  end

endmodule

// ==== verification/ebusCtl_assert.sv ====
`timescale 1ns/1ps

module ebusCtlAssert (
  input logic              clk60,
  input logic              rstN,
  input logic              demand,
  input ebusPkg::tEbusFunc func,
  input logic              respPush,
  input logic              respValid,
  input logic [7:0]        creditCnt
);

  // One bus strobe per pop and never back to back
  demandSingle: assert property (@(posedge clk60) disable iff (!rstN)
    demand |=> !demand)
    else $error("demand held for two consecutive cycles");

  // Push only in the capture cycle of a read
  pushAfterRead: assert property (@(posedge clk60) disable iff (!rstN)
    respPush |-> $past(demand && ebusPkg::isRead(func)))
    else $error("respPush without a read bus cycle before it");

  // Host credit must be held while a response is out
  creditHeld: assert property (@(posedge clk60) disable iff (!rstN)
    respValid |-> (creditCnt != '0))
    else $error("respValid with a zero credit count");

endmodule

bind ebusCtl ebusCtlAssert chk (
  .clk60, .rstN, .demand(bus.demand), .func(bus.func),
  .respPush, .respValid, .creditCnt
);

// ==== verification/ebusTb.sv ====
`timescale 1ns/1ps

module ebusTb;

  localparam int NumDev    = 4;
  localparam int CmdDepth  = 4;
  localparam int Phase1Len = 6;  // Steps sent while response credits are withheld

  typedef struct {
    ebusPkg::tDevId    dev;
    ebusPkg::tEbusFunc func;
    ebusPkg::tEbusWord data;
  } tStep;

  logic              clk60 = 1'b0;
  logic              rstN, cmdValid, cmdCredit, respCredit, respValid;
  ebusPkg::tDevId    cmdDev, respDev;
  ebusPkg::tEbusFunc cmdFunc;
  ebusPkg::tEbusWord cmdData, respData;

  integer            seed = 32'h4c12;
  tStep              steps[$];         // Stimulus table
  ebusPkg::tEbusResp expQ[$];          // Expected responses in command order
  ebusPkg::tEbusWord dataModel [8];    // All eight ids where absent ones stay zero
  logic [18:35]      condModel [8];
  int hostCredits = CmdDepth;          // Command slots the host may fill
  int creditBudget = 0;                // Response credits still to return
  int creditPulses = 0;
  int respCount = 0;
  int valErrs = 0;
  int otherErrs = 0;
  int cycle = 0;

  ebusTop #(.NumDev(NumDev), .CmdDepth(CmdDepth), .RespDepth(4)) DUT (.*);

  always #2 clk60 = ~clk60;                  // 4 ns period
  always @(posedge clk60) cycle <= cycle + 1;

  task automatic checkWord(input string name, input ebusPkg::tEbusWord exp,
                           input ebusPkg::tEbusWord act);
    if (act !== exp) begin
      $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
      valErrs++;
    end
  endtask

  task automatic checkDev(input string name, input ebusPkg::tDevId exp,
                          input ebusPkg::tDevId act);
    if (act !== exp) begin
      $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
      valErrs++;
    end
  endtask

  function automatic ebusPkg::tEbusWord randWord();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi[3:0], lo};  // 36 bits from two draws
  endfunction

  task automatic addStep(input ebusPkg::tDevId dev, input ebusPkg::tEbusFunc func,
                         input ebusPkg::tEbusWord data);
    steps.push_back('{dev, func, data});
  endtask

  task automatic buildTable();
    addStep(3'd1, ebusPkg::fDatao, randWord());
    addStep(3'd1, ebusPkg::fDatai, '0);
    addStep(3'd2, ebusPkg::fCono, randWord());
    addStep(3'd2, ebusPkg::fConi, '0);
    addStep(3'd2, ebusPkg::fDatai, '0);  // CONO leaves the data register alone
    addStep(3'd3, ebusPkg::fDatai, '0);  // Never written
    // Ids past NumDev have no device behind them
    addStep(3'd6, ebusPkg::fDatai, '0);
    addStep(3'd5, ebusPkg::fConi, '0);
    addStep(3'd7, ebusPkg::fDatao, randWord());
    addStep(3'd7, ebusPkg::fDatai, '0);
    for (int i = 0; i < NumDev; i++) begin  // Interleaved writes
      addStep(ebusPkg::tDevId'(i), ebusPkg::fDatao, randWord());
      addStep(ebusPkg::tDevId'(NumDev - 1 - i), ebusPkg::fCono, randWord());
    end
    for (int i = 0; i < NumDev; i++) begin
      addStep(ebusPkg::tDevId'(NumDev - 1 - i), ebusPkg::fDatai, '0);
      addStep(ebusPkg::tDevId'(i), ebusPkg::fConi, '0);
    end
    addStep(3'd1, ebusPkg::fDatao, 36'h800000001);  // Bits 0 and 35 set
    addStep(3'd1, ebusPkg::fCono, 36'hfffffffff);
    addStep(3'd1, ebusPkg::fConi, '0);              // Left half must read zero
    addStep(3'd1, ebusPkg::fDatai, '0);
  endtask

  // Reference model of the device registers and the read results
  task automatic modelStep(input tStep s);
    ebusPkg::tEbusResp r;
    r.dev  = s.dev;
    r.data = '0;
    case (s.func)
      ebusPkg::fDatao: if (s.dev < NumDev) dataModel[s.dev] = s.data;
      ebusPkg::fCono:  if (s.dev < NumDev) condModel[s.dev] = s.data[18:35];
      ebusPkg::fDatai: r.data = dataModel[s.dev];
      default:         r.data = {18'b0, condModel[s.dev]};
    endcase
    if (ebusPkg::isRead(s.func)) expQ.push_back(r);
  endtask

  task automatic sendStep(input tStep s);
    while (hostCredits == 0) @(negedge clk60);  // Hold until a slot comes back
    cmdValid = 1'b1;
    cmdDev   = s.dev;
    cmdFunc  = s.func;
    cmdData  = s.data;
    hostCredits--;
    modelStep(s);
    @(negedge clk60);
    cmdValid = 1'b0;
  endtask

  initial begin : creditReturn
    respCredit = 1'b0;
    forever begin
      @(negedge clk60);
      if (creditBudget > 0 && cycle % 8 < 3) begin  // Bursts of three
        respCredit = 1'b1;
        creditBudget--;
      end else begin
        respCredit = 1'b0;
      end
    end
  end

  always @(posedge clk60) begin : monitor
    ebusPkg::tEbusResp expResp;
    if (rstN && cmdCredit) begin
      hostCredits++;
      creditPulses++;
    end
    if (rstN && respValid) begin
      respCount++;
      if (expQ.size() == 0) begin
        $display("Unexpected respValid at %0t with no read outstanding", $time);
        otherErrs++;
      end else begin
        expResp = expQ.pop_front();
        checkDev("respDev", expResp.dev, respDev);
        checkWord("respData", expResp.data, respData);
      end
    end
  end

  initial begin : mainFlow
    int reads;
    int totalReads;
    rstN     = 1'b0;
    cmdValid = 1'b0;
    cmdDev   = '0;
    cmdFunc  = ebusPkg::fDatao;
    cmdData  = '0;
    for (int i = 0; i < 8; i++) begin
      dataModel[i] = '0;
      condModel[i] = '0;
    end
    buildTable();
    repeat (2) @(posedge clk60);
    @(negedge clk60);
    rstN = 1'b1;
    reads = 0;
    for (int i = 0; i < Phase1Len; i++) begin  // No response credits yet
      sendStep(steps[i]);
      if (ebusPkg::isRead(steps[i].func)) reads++;
    end
    repeat (30) @(negedge clk60);
    if (respCount != 0) begin
      $display("respValid appeared while no response credits were granted");
      otherErrs++;
    end
    creditBudget = reads - 1;  // Last response stays queued without its credit
    while (respCount < reads - 1) @(negedge clk60);
    repeat (20) @(negedge clk60);
    if (respCount != reads - 1) begin
      $display("Granted %0d response credits but saw %0d responses", reads - 1, respCount);
      otherErrs++;
    end
    creditBudget = 1;
    while (respCount < reads) @(negedge clk60);
    totalReads = reads;
    reads = 0;
    for (int i = Phase1Len; i < steps.size(); i++) begin
      if (ebusPkg::isRead(steps[i].func)) reads++;
    end
    creditBudget = reads;
    totalReads += reads;
    for (int i = Phase1Len; i < steps.size(); i++) sendStep(steps[i]);
    while (expQ.size() != 0) @(negedge clk60);
    repeat (10) @(negedge clk60);
    if (creditPulses != steps.size()) begin
      $display("cmdCredit pulsed %0d times for %0d commands", creditPulses, steps.size());
      otherErrs++;
    end
    if (respCount != totalReads) begin
      $display("Saw %0d responses for %0d reads", respCount, totalReads);
      otherErrs++;
    end
    $display("Errors: %0d wrong values, %0d other failures", valErrs, otherErrs);
    if (valErrs + otherErrs == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    @(posedge rstN);
    repeat (steps.size() * 10 + 200) @(posedge clk60);  // Scales with the table
    otherErrs++;
    $display("Timeout with %0d responses still outstanding", expQ.size());
    $display("Errors: %0d wrong values, %0d other failures", valErrs, otherErrs);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule
